/* vc_pkg.sv */
/*
 * widths, protocol constants and enums shared by the
 * StartViewChange engine
 */
`default_nettype none

package vc_pkg;

    localparam int VIEW_W      = 32;
    localparam int MAX_CLUSTER = 8;
    localparam int NODE_IDX_W  = 3;
    localparam int NODE_CNT_W  = 4;
    localparam int COUNT_W     = 4;
    localparam int IP_W        = 32;
    localparam int PORT_W      = 16;
    localparam int LEN_W       = 16;

    // generic header: fragment, type, length
    localparam logic [15:0] NONFRAG_MAGIC = 16'hfff0;
    localparam int BEEHIVE_HDR_BYTES = 5;
    // StartViewChange body: view, replica index, last_commit
    localparam int SVC_HDR_BYTES = 9;

    localparam int PAYLOAD_W = 128;
    localparam int SVC_PAD_W = PAYLOAD_W - 8 * (BEEHIVE_HDR_BYTES + SVC_HDR_BYTES);

    typedef enum logic [7:0] {
        MSG_START_VIEW_CHANGE = 8'd3,
        MSG_DO_VIEW_CHANGE    = 8'd4,
        MSG_START_VIEW        = 8'd5
    } vc_msg_type_e;

    typedef enum logic [1:0] {
        STATUS_NORMAL      = 2'd0,
        STATUS_VIEW_CHANGE = 2'd1
    } vc_status_e;

    // decoder verdict for one message
    typedef enum logic [1:0] {
        ACT_DROP      = 2'd0,
        ACT_NEW_VIEW  = 2'd1,
        ACT_SAME_VIEW = 2'd2
    } vc_action_e;

endpackage

`default_nettype wire

/* vc_msg_decode.sv */
/*
 * message intake stage, registers one message and classifies it
 * against the presented replica state
 */
`timescale 1ns/1ps
`default_nettype none

module vc_msg_decode
    import vc_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               arst_n,

    input  wire logic               msg_val,
    output logic                    msg_rdy,
    input  wire vc_msg_type_e       msg_type,
    input  wire logic [VIEW_W-1:0]  msg_view,
    input  wire logic [NODE_IDX_W-1:0] msg_rep_index,

    input  wire logic [VIEW_W-1:0]  curr_view,
    input  wire vc_status_e         curr_status,

    input  wire logic               busy,

    output logic                    act_val,
    output vc_action_e              act,
    output logic [VIEW_W-1:0]       act_view,
    output logic [NODE_IDX_W-1:0]   act_rep_index
);

    logic       accept;
    vc_action_e verdict;

    // one message in flight, the rest of the engine holds us off via busy
    assign msg_rdy = ~act_val & ~busy;
    assign accept  = msg_val & msg_rdy;

    always_comb begin
        verdict = ACT_DROP;
        if (msg_type == MSG_START_VIEW_CHANGE) begin
            if (msg_view > curr_view) begin
                verdict = ACT_NEW_VIEW;
            end else if (msg_view == curr_view && curr_status == STATUS_VIEW_CHANGE) begin
                verdict = ACT_SAME_VIEW;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            act_val <= 1'b0;
        end else begin
            act_val <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            act           <= verdict;
            act_view      <= msg_view;
            act_rep_index <= msg_rep_index;
        end
    end

endmodule

`default_nettype wire

/* vc_quorum_track.sv */
/*
 * sender vector and count for the current view, quorum pulse
 * and state write-back on a view change
 */
`timescale 1ns/1ps
`default_nettype none

module vc_quorum_track
    import vc_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    input  wire logic                   act_val,
    input  wire vc_action_e             act,
    input  wire logic [VIEW_W-1:0]      act_view,
    input  wire logic [NODE_IDX_W-1:0]  act_rep_index,

    input  wire logic [NODE_CNT_W-1:0]  node_count,

    output logic                        state_wr_val,
    input  wire logic                   state_wr_rdy,
    output logic [VIEW_W-1:0]           state_wr_view,
    output vc_status_e                  state_wr_status,

    output logic                        bcast_start,
    output logic [VIEW_W-1:0]           bcast_view,

    output logic                        quorum_reached,
    output logic [VIEW_W-1:0]           quorum_view,

    output logic                        busy
);

    logic [MAX_CLUSTER-1:0] vec;
    logic [VIEW_W-1:0]      vec_view;
    logic [NODE_IDX_W-1:0]  new_idx;
    logic [MAX_CLUSTER-1:0] act_bit;
    logic [MAX_CLUSTER-1:0] new_bit;
    logic [COUNT_W-1:0]     count;
    logic                   wr_done;
    logic                   same_view;
    logic                   upd;
    logic                   fired;
    logic                   reach;

    assign wr_done   = state_wr_val & state_wr_rdy;
    assign same_view = act_val & (act == ACT_SAME_VIEW);
    assign act_bit   = MAX_CLUSTER'(1) << act_rep_index;
    assign new_bit   = MAX_CLUSTER'(1) << new_idx;

    // only view-change writes leave this stage
    assign state_wr_status = STATUS_VIEW_CHANGE;
    assign bcast_view      = vec_view;
    assign quorum_view     = vec_view;
    assign busy            = state_wr_val | bcast_start;

    always_comb begin
        count = '0;
        for (int i = 0; i < MAX_CLUSTER; i++) begin
            count = count + COUNT_W'(vec[i]);
        end
    end

    assign reach = upd & ~fired & (count >= COUNT_W'(node_count >> 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_wr_val   <= 1'b0;
            bcast_start    <= 1'b0;
            quorum_reached <= 1'b0;
            upd            <= 1'b0;
            fired          <= 1'b0;
            vec            <= '0;
            vec_view       <= '0;
        end else begin
            bcast_start    <= wr_done;
            upd            <= wr_done | same_view;
            quorum_reached <= reach;
            if (reach) begin
                fired <= 1'b1;
            end

            if (act_val && act == ACT_NEW_VIEW) begin
                state_wr_val <= 1'b1;
            end else if (wr_done) begin
                state_wr_val <= 1'b0;
            end

            if (wr_done) begin
                vec      <= new_bit;
                vec_view <= state_wr_view;
                fired    <= 1'b0;
            end else if (same_view) begin
                // state may have entered this view without us
                if (act_view != vec_view) begin
                    vec      <= act_bit;
                    vec_view <= act_view;
                    fired    <= 1'b0;
                end else begin
                    vec <= vec | act_bit;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (act_val && act == ACT_NEW_VIEW) begin
            state_wr_view <= act_view;
            new_idx       <= act_rep_index;
        end
    end

    // sender indices come from the message intake
    a_vec_in_cluster: assert property (@(posedge clk) disable iff (!arst_n)
        (vec >> node_count) == '0);

endmodule

`default_nettype wire

/* vc_broadcast.sv */
/*
 * walks the peer indices in ascending order, reads each address
 * from the configuration RAM and hands one send per peer to format
 */
`timescale 1ns/1ps
`default_nettype none

module vc_broadcast
    import vc_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    input  wire logic                   bcast_start,
    input  wire logic [VIEW_W-1:0]      bcast_view,

    input  wire logic [NODE_CNT_W-1:0]  node_count,
    input  wire logic [NODE_IDX_W-1:0]  my_index,

    output logic                        cfg_rd_val,
    output logic [NODE_IDX_W-1:0]       cfg_rd_addr,
    input  wire logic [IP_W-1:0]        cfg_rd_ip,
    input  wire logic [PORT_W-1:0]      cfg_rd_port,

    output logic                        send_val,
    input  wire logic                   send_rdy,
    output logic [NODE_IDX_W-1:0]       dst_idx,
    output logic [IP_W-1:0]             dst_ip,
    output logic [PORT_W-1:0]           dst_port,
    output logic [VIEW_W-1:0]           send_view,

    output logic                        busy
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        SEND
    } bcast_state_e;

    bcast_state_e           state;
    logic [NODE_IDX_W-1:0]  idx;
    logic [NODE_CNT_W-1:0]  first_cnt;
    logic [NODE_CNT_W-1:0]  next_cnt;
    logic                   rd_pend;
    logic [IP_W-1:0]        ip_q;
    logic [PORT_W-1:0]      port_q;
    logic [VIEW_W-1:0]      view_q;

    // wide enough to step past the last index without wrapping
    always_comb begin
        first_cnt = (my_index == '0) ? NODE_CNT_W'(1) : '0;
        next_cnt  = NODE_CNT_W'(idx) + 1'b1;
        if (next_cnt == NODE_CNT_W'(my_index)) begin
            next_cnt = next_cnt + 1'b1;
        end
    end

    assign cfg_rd_val  = (state == READ);
    assign cfg_rd_addr = idx;
    assign send_val    = (state == SEND);
    assign dst_idx     = idx;
    // read data is only valid for one cycle, afterwards use the copy
    assign dst_ip      = rd_pend ? cfg_rd_ip : ip_q;
    assign dst_port    = rd_pend ? cfg_rd_port : port_q;
    assign send_view   = view_q;
    // stays up while format still holds a packet
    assign busy        = (state != IDLE) | ~send_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            idx     <= '0;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= (state == READ);
            case (state)
                IDLE: begin
                    if (bcast_start && first_cnt < node_count) begin
                        idx   <= first_cnt[NODE_IDX_W-1:0];
                        state <= READ;
                    end
                end
                READ: begin
                    state <= SEND;
                end
                SEND: begin
                    if (send_rdy) begin
                        if (next_cnt < node_count) begin
                            idx   <= next_cnt[NODE_IDX_W-1:0];
                            state <= READ;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && bcast_start) begin
            view_q <= bcast_view;
        end
        if (rd_pend) begin
            ip_q   <= cfg_rd_ip;
            port_q <= cfg_rd_port;
        end
    end

    a_peer_only: assert property (@(posedge clk) disable iff (!arst_n)
        send_val |-> dst_idx != my_index && NODE_CNT_W'(dst_idx) < node_count);

endmodule

`default_nettype wire

/* vc_udp_format.sv */
/*
 * builds the UDP metadata and StartViewChange payload and holds
 * them until the output takes them
 */
`timescale 1ns/1ps
`default_nettype none

module vc_udp_format
    import vc_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    input  wire logic                   send_val,
    output logic                        send_rdy,
    input  wire logic [IP_W-1:0]        dst_ip,
    input  wire logic [PORT_W-1:0]      dst_port,
    input  wire logic [VIEW_W-1:0]      send_view,

    input  wire logic [NODE_IDX_W-1:0]  my_index,
    input  wire logic [VIEW_W-1:0]      last_commit,
    input  wire logic [IP_W-1:0]        our_ip,
    input  wire logic [PORT_W-1:0]      our_port,

    output logic                        out_val,
    input  wire logic                   out_rdy,
    output logic [IP_W-1:0]             out_src_ip,
    output logic [PORT_W-1:0]           out_src_port,
    output logic [IP_W-1:0]             out_dst_ip,
    output logic [PORT_W-1:0]           out_dst_port,
    output logic [LEN_W-1:0]            out_length,
    output logic [PAYLOAD_W-1:0]        out_data
);

    logic load;

    assign send_rdy   = ~out_val | out_rdy;
    assign load       = send_val & send_rdy;
    assign out_length = LEN_W'(BEEHIVE_HDR_BYTES + SVC_HDR_BYTES);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_val <= 1'b0;
        end else if (load) begin
            out_val <= 1'b1;
        end else if (out_rdy) begin
            out_val <= 1'b0;
        end
    end

    // message sits at the top of the word in header order
    always_ff @(posedge clk) begin
        if (load) begin
            out_src_ip   <= our_ip;
            out_src_port <= our_port;
            out_dst_ip   <= dst_ip;
            out_dst_port <= dst_port;
            out_data     <= {NONFRAG_MAGIC, MSG_START_VIEW_CHANGE, LEN_W'(SVC_HDR_BYTES),
                             send_view, 8'(my_index), last_commit, {SVC_PAD_W{1'b0}}};
        end
    end

    a_hold_packet: assert property (@(posedge clk) disable iff (!arst_n)
        out_val && !out_rdy |=> out_val && $stable(out_data) && $stable(out_dst_ip));

endmodule

`default_nettype wire

/* view_change_eng.sv */
/*
 * StartViewChange engine top, decode, quorum, broadcast and
 * packet format stages in a chain
 */
`timescale 1ns/1ps
`default_nettype none

module view_change_eng
    import vc_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    input  wire logic                   msg_val,
    output logic                        msg_rdy,
    input  wire vc_msg_type_e           msg_type,
    input  wire logic [VIEW_W-1:0]      msg_view,
    input  wire logic [NODE_IDX_W-1:0]  msg_rep_index,

    input  wire logic [VIEW_W-1:0]      curr_view,
    input  wire vc_status_e             curr_status,
    input  wire logic [NODE_IDX_W-1:0]  my_index,
    input  wire logic [VIEW_W-1:0]      last_commit,
    input  wire logic [NODE_CNT_W-1:0]  node_count,
    input  wire logic [IP_W-1:0]        our_ip,
    input  wire logic [PORT_W-1:0]      our_port,

    output logic                        state_wr_val,
    input  wire logic                   state_wr_rdy,
    output logic [VIEW_W-1:0]           state_wr_view,
    output vc_status_e                  state_wr_status,

    output logic                        cfg_rd_val,
    output logic [NODE_IDX_W-1:0]       cfg_rd_addr,
    input  wire logic [IP_W-1:0]        cfg_rd_ip,
    input  wire logic [PORT_W-1:0]      cfg_rd_port,

    output logic                        out_val,
    input  wire logic                   out_rdy,
    output logic [IP_W-1:0]             out_src_ip,
    output logic [PORT_W-1:0]           out_src_port,
    output logic [IP_W-1:0]             out_dst_ip,
    output logic [PORT_W-1:0]           out_dst_port,
    output logic [LEN_W-1:0]            out_length,
    output logic [PAYLOAD_W-1:0]        out_data,

    output logic                        quorum_reached,
    output logic [VIEW_W-1:0]           quorum_view
);

    logic                   act_val;
    vc_action_e             act;
    logic [VIEW_W-1:0]      act_view;
    logic [NODE_IDX_W-1:0]  act_rep_index;

    logic                   bcast_start;
    logic [VIEW_W-1:0]      bcast_view;

    logic                   send_val;
    logic                   send_rdy;
    logic [IP_W-1:0]        dst_ip;
    logic [PORT_W-1:0]      dst_port;
    logic [VIEW_W-1:0]      send_view;

    logic                   quorum_busy;
    logic                   bcast_busy;
    logic                   eng_busy;

    assign eng_busy = quorum_busy | bcast_busy;

    vc_msg_decode decode (
        .clk            (clk),
        .arst_n         (arst_n),
        .msg_val        (msg_val),
        .msg_rdy        (msg_rdy),
        .msg_type       (msg_type),
        .msg_view       (msg_view),
        .msg_rep_index  (msg_rep_index),
        .curr_view      (curr_view),
        .curr_status    (curr_status),
        .busy           (eng_busy),
        .act_val        (act_val),
        .act            (act),
        .act_view       (act_view),
        .act_rep_index  (act_rep_index)
    );

    vc_quorum_track quorum (
        .clk             (clk),
        .arst_n          (arst_n),
        .act_val         (act_val),
        .act             (act),
        .act_view        (act_view),
        .act_rep_index   (act_rep_index),
        .node_count      (node_count),
        .state_wr_val    (state_wr_val),
        .state_wr_rdy    (state_wr_rdy),
        .state_wr_view   (state_wr_view),
        .state_wr_status (state_wr_status),
        .bcast_start     (bcast_start),
        .bcast_view      (bcast_view),
        .quorum_reached  (quorum_reached),
        .quorum_view     (quorum_view),
        .busy            (quorum_busy)
    );

    vc_broadcast bcast (
        .clk         (clk),
        .arst_n      (arst_n),
        .bcast_start (bcast_start),
        .bcast_view  (bcast_view),
        .node_count  (node_count),
        .my_index    (my_index),
        .cfg_rd_val  (cfg_rd_val),
        .cfg_rd_addr (cfg_rd_addr),
        .cfg_rd_ip   (cfg_rd_ip),
        .cfg_rd_port (cfg_rd_port),
        .send_val    (send_val),
        .send_rdy    (send_rdy),
        .dst_idx     (),
        .dst_ip      (dst_ip),
        .dst_port    (dst_port),
        .send_view   (send_view),
        .busy        (bcast_busy)
    );

    vc_udp_format format (
        .clk          (clk),
        .arst_n       (arst_n),
        .send_val     (send_val),
        .send_rdy     (send_rdy),
        .dst_ip       (dst_ip),
        .dst_port     (dst_port),
        .send_view    (send_view),
        .my_index     (my_index),
        .last_commit  (last_commit),
        .our_ip       (our_ip),
        .our_port     (our_port),
        .out_val      (out_val),
        .out_rdy      (out_rdy),
        .out_src_ip   (out_src_ip),
        .out_src_port (out_src_port),
        .out_dst_ip   (out_dst_ip),
        .out_dst_port (out_dst_port),
        .out_length   (out_length),
        .out_data     (out_data)
    );

endmodule

`default_nettype wire

/* tb_vc_ref.svh */
/*
 * expected StartViewChange payload, peer address table and the
 * compare task used by the engine testbench
 */
`ifndef TB_VC_REF_SVH
`define TB_VC_REF_SVH

// fragment, type, body length, then view, sender index, commit and zero fill
function automatic logic [127:0] svc_payload(input logic [31:0] view,
                                             input logic [2:0]  idx,
                                             input logic [31:0] commit);
    return {NONFRAG_MAGIC, 8'(MSG_START_VIEW_CHANGE), 16'd9, view,
            5'd0, idx, commit, 16'h0000};
endfunction

// every replica index gets its own address and port
function automatic logic [31:0] peer_ip(input logic [2:0] idx);
    return 32'h0a00_0100 + 32'(idx) * 32'd17;
endfunction

function automatic logic [15:0] peer_port(input logic [2:0] idx);
    return 16'd9001 + 16'(idx) * 16'd3;
endfunction

task automatic abort_run(input string why);
    $display("Error at %0t: %s", $time, why);
    $display("Simulation FAILED");
    $fatal(1);
endtask

task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
        $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        $display("Simulation FAILED");
        $fatal(1);
    end
endtask

`endif

/* tb_view_change_eng.sv */
/*
 * testbench for the StartViewChange engine with state and config RAM
 * models, a reference model with expected queues, and a watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_view_change_eng
    import vc_pkg::*;
();

    localparam logic [31:0] SEED = 32'h36ec;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_MSG = 300;
    localparam int NUM_DIRECTED = 10;
    localparam int NUM_RAND_A = 20;
    localparam int NUM_RAND_B = 12;
    localparam int NUM_MSGS = NUM_DIRECTED + NUM_RAND_A + NUM_RAND_B;
    localparam logic [31:0] START_VIEW = 32'd10;

    logic clk = 1'b0;
    logic arst_n;
    logic msg_val, msg_rdy;
    vc_msg_type_e msg_type;
    logic [31:0] msg_view, curr_view, last_commit, state_wr_view, quorum_view, our_ip;
    logic [31:0] cfg_rd_ip, out_src_ip, out_dst_ip;
    logic [2:0] msg_rep_index, my_index, cfg_rd_addr;
    vc_status_e curr_status, state_wr_status;
    logic [3:0] node_count;
    logic [15:0] our_port, cfg_rd_port, out_src_port, out_dst_port, out_length;
    logic state_wr_val, state_wr_rdy, cfg_rd_val, out_val, out_rdy, quorum_reached;
    logic [127:0] out_data;

    // reference model state and expected events
    logic [31:0] m_view;
    vc_status_e m_status;
    logic [7:0] m_vec;
    logic m_fired;
    logic bp;
    logic [31:0] exp_wr[$], exp_view[$], exp_q[$];
    logic [2:0] exp_idx[$];
    logic [2:0] pk_idx;
    logic [31:0] pk_view;
    int pkt_seen, q_seen;

    `include "tb_vc_ref.svh"

    view_change_eng DUT (.*);

    always #2 clk = ~clk;

    // replica state register, written through the state write port
    always @(posedge clk) begin
        if (arst_n && state_wr_val && state_wr_rdy) begin
            curr_view   <= state_wr_view;
            curr_status <= state_wr_status;
        end
    end

    // config RAM, one cycle read latency
    always @(posedge clk) begin
        if (cfg_rd_val) begin
            cfg_rd_ip   <= peer_ip(cfg_rd_addr);
            cfg_rd_port <= peer_port(cfg_rd_addr);
        end
    end

    function automatic int bits_set(input logic [7:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            n += int'(v[i]);
        end
        return n;
    endfunction

    // expected events for one message, from the protocol rules
    task automatic model_msg(input vc_msg_type_e t, input logic [31:0] v, input logic [2:0] s);
        logic upd;
        int i;
        upd = 1'b0;
        if (t == MSG_START_VIEW_CHANGE && v > m_view) begin
            exp_wr.push_back(v);
            for (i = 0; i < int'(node_count); i++) begin
                if (i != int'(my_index)) begin
                    exp_idx.push_back(3'(i));
                    exp_view.push_back(v);
                end
            end
            m_view = v;
            m_status = STATUS_VIEW_CHANGE;
            m_vec = 8'(1) << s;
            m_fired = 1'b0;
            upd = 1'b1;
        end else if (t == MSG_START_VIEW_CHANGE && v == m_view && m_status == STATUS_VIEW_CHANGE) begin
            m_vec = m_vec | (8'(1) << s);
            upd = 1'b1;
        end
        if (upd && !m_fired && bits_set(m_vec) >= int'(node_count >> 1)) begin
            exp_q.push_back(m_view);
            m_fired = 1'b1;
        end
    endtask

    task automatic send_msg(input vc_msg_type_e t, input logic [31:0] v, input logic [2:0] s);
        @(posedge clk);
        msg_val       <= 1'b1;
        msg_type      <= t;
        msg_view      <= v;
        msg_rep_index <= s;
        model_msg(t, v, s);
        do @(posedge clk); while (!msg_rdy);
        msg_val <= 1'b0;
        // handling ends when msg_rdy is back
        do @(posedge clk); while (!msg_rdy);
        @(negedge clk);
        check("state writes pending at msg_rdy", exp_wr.size(), 0);
        check("packets pending at msg_rdy", exp_idx.size(), 0);
    endtask

    task automatic random_msgs(input int n);
        vc_msg_type_e t;
        logic [31:0] v;
        int k;
        for (k = 0; k < n; k++) begin
            case ($urandom % 6)
                0: t = MSG_DO_VIEW_CHANGE;
                1: t = MSG_START_VIEW;
                default: t = MSG_START_VIEW_CHANGE;
            endcase
            case ($urandom % 4)
                0: v = m_view - 1;
                3: v = m_view + 1;
                default: v = m_view;
            endcase
            send_msg(t, v, 3'($urandom % node_count));
        end
    endtask

    // quorum pulse trails msg_rdy by at most two cycles
    task automatic drain();
        repeat (4) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            out_rdy      <= bp ? 1'($urandom % 2) : 1'b1;
            state_wr_rdy <= bp ? 1'($urandom % 2) : 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            if (cfg_rd_val && exp_idx.size() == 0) begin
                abort_run("config RAM read outside a broadcast");
            end
            if (state_wr_val && state_wr_rdy) begin
                if (exp_wr.size() == 0) begin
                    abort_run("state write where none was expected");
                end else begin
                    check("state_wr_view", state_wr_view, exp_wr.pop_front());
                    check("state_wr_status", state_wr_status, STATUS_VIEW_CHANGE);
                end
            end
            if (out_val && out_rdy) begin
                if (exp_idx.size() == 0) begin
                    abort_run("packet sent where none was expected");
                end else begin
                    pk_idx = exp_idx.pop_front();
                    pk_view = exp_view.pop_front();
                    check("out_dst_ip", out_dst_ip, peer_ip(pk_idx));
                    check("out_dst_port", out_dst_port, peer_port(pk_idx));
                    check("out_src_ip", out_src_ip, our_ip);
                    check("out_src_port", out_src_port, our_port);
                    check("out_length", out_length, 14);
                    check("out_data", out_data, svc_payload(pk_view, my_index, last_commit));
                    pkt_seen++;
                end
            end
            if (quorum_reached) begin
                if (exp_q.size() == 0) begin
                    abort_run("quorum pulse where none was expected");
                end else begin
                    check("quorum_view", quorum_view, exp_q.pop_front());
                    q_seen++;
                end
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_MSGS * CYCLES_PER_MSG) @(posedge clk);
        $display("Timeout: run exceeded %0d cycles", RESET_CYCLES + NUM_MSGS * CYCLES_PER_MSG);
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(SEED));
        arst_n = 1'b0;
        msg_val = 1'b0;
        msg_type = MSG_START_VIEW_CHANGE;
        msg_view = '0;
        msg_rep_index = '0;
        curr_view = START_VIEW;
        curr_status = STATUS_NORMAL;
        my_index = 3'd2;
        node_count = 4'd5;
        last_commit = $urandom;
        our_ip = 32'hc0a8_0a02;
        our_port = 16'd7000;
        state_wr_rdy = 1'b1;
        out_rdy = 1'b1;
        cfg_rd_ip = '0;
        cfg_rd_port = '0;
        m_view = START_VIEW;
        m_status = STATUS_NORMAL;
        m_vec = '0;
        m_fired = 1'b0;
        bp = 1'b0;
        pkt_seen = 0;
        q_seen = 0;
        fork
            drive_ready();
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("msg_rdy", msg_rdy, 1);
        check("state_wr_val", state_wr_val, 0);
        check("cfg_rd_val", cfg_rd_val, 0);
        check("out_val", out_val, 0);
        check("quorum_reached", quorum_reached, 0);

        // stale view, current view while normal, then the other types
        send_msg(MSG_START_VIEW_CHANGE, START_VIEW - 1, 3'd1);
        send_msg(MSG_START_VIEW_CHANGE, START_VIEW, 3'd1);
        send_msg(MSG_DO_VIEW_CHANGE, START_VIEW + 1, 3'd3);
        send_msg(MSG_START_VIEW, START_VIEW + 2, 3'd4);
        // new view, repeat sender, then quorum at the second distinct one
        send_msg(MSG_START_VIEW_CHANGE, START_VIEW + 1, 3'd0);
        send_msg(MSG_START_VIEW_CHANGE, START_VIEW + 1, 3'd0);
        send_msg(MSG_START_VIEW_CHANGE, START_VIEW + 1, 3'd3);
        send_msg(MSG_START_VIEW_CHANGE, START_VIEW + 1, 3'd4);
        send_msg(MSG_START_VIEW_CHANGE, START_VIEW, 3'd1);
        send_msg(MSG_DO_VIEW_CHANGE, START_VIEW + 1, 3'd1);
        drain();
        check("packets in directed run", pkt_seen, 4);
        check("quorum pulses in directed run", q_seen, 1);

        bp <= 1'b1;
        random_msgs(NUM_RAND_A);
        drain();
        // larger cluster, local replica at index 0
        @(posedge clk);
        node_count <= 4'd6;
        my_index <= 3'd0;
        last_commit <= $urandom;
        random_msgs(NUM_RAND_B);
        drain();
        check("state writes never seen", exp_wr.size(), 0);
        check("packets never seen", exp_idx.size(), 0);
        check("quorum pulses never seen", exp_q.size(), 0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
vc_pkg.sv
vc_msg_decode.sv
vc_quorum_track.sv
vc_broadcast.sv
vc_udp_format.sv
view_change_eng.sv
tb_view_change_eng.sv
